/* Makefile */
# Verilator build and run of the falling-tile game testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module pianoTilesTb -f files.f -Mdir obj_dir
	./obj_dir/VpianoTilesTb +verilator+error+limit+1000 | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

/* files.f */
pianoTilesPkg.sv
tileTimer.sv
tileSlot.sv
gameControl.sv
pixelPlotter.sv
scoreDisplay.sv
pianoTiles.sv
pianoTiles_asserts.sv
pianoTilesTb.sv

/* gameControl.sv */
`timescale 1ns/100ps
`default_nettype none

module gameControl (
	input wire logic CLOCK_50,
	input wire logic rstN,
	input wire logic [3:0] KEY,
	input wire pianoTilesPkg::tileState_t tiles [4],
	input wire logic [3:0] leave,
	input wire logic sweepDone,
	input wire logic spawnTick,
	input wire pianoTilesPkg::column_t spawnColumn,
	output logic [3:0] spawn,
	output pianoTilesPkg::column_t slotColumn,
	output logic [3:0] markScored,
	output logic clearTiles,
	output pianoTilesPkg::phase_t phase,
	output pianoTilesPkg::score_t score
);

	logic [3:0] keySync1;
	logic [3:0] keySync2;
	logic [3:0] keyPrev;
	logic [3:0] keyFall;

	// Press per column, KEY[3] drives column 0
	logic [3:0] press;
	logic [3:0] markNext;
	logic [2:0] hitCount;
	logic missNext;
	logic found;
	logic [3:0] spawnNext;

	assign press = {keyFall[0], keyFall[1], keyFall[2], keyFall[3]};

	always_comb
	begin
		markNext = '0;
		hitCount = '0;
		missNext = 1'b0;
		found = 1'b0;
		for (int c = 0; c < 4; c++)
		begin
			found = 1'b0;
			for (int i = 0; i < 4; i++)
			begin
				if (press[c] && !found && tiles[i].onScreen
					&& tiles[i].column == pianoTilesPkg::column_t'(c)
					&& tiles[i].yTop >= pianoTilesPkg::HIT_TOP)
				begin
					found = 1'b1;
					markNext[i] = 1'b1;
					if (!tiles[i].scored)
						hitCount = hitCount + 1'b1;
				end
			end
			if (press[c] && !found)
				missNext = 1'b1;
		end
		// Tile fell off the bottom without being hit
		for (int i = 0; i < 4; i++)
		begin
			if (leave[i] && !tiles[i].scored)
				missNext = 1'b1;
		end
	end

	// Lowest free slot takes the next tile
	always_comb
	begin
		spawnNext = '0;
		for (int i = 3; i >= 0; i--)
		begin
			if (!tiles[i].onScreen)
				spawnNext = 4'(1 << i);
		end
	end

	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			keySync1 <= '1;
			keySync2 <= '1;
			keyPrev <= '1;
			keyFall <= '0;
			phase <= pianoTilesPkg::sweepBackground;
			score <= '0;
			spawn <= '0;
			slotColumn <= '0;
			markScored <= '0;
			clearTiles <= 1'b0;
		end
		else
		begin
			keySync1 <= KEY;
			keySync2 <= keySync1;
			keyPrev <= keySync2;
			keyFall <= keyPrev & ~keySync2;
			spawn <= '0;
			markScored <= '0;
			clearTiles <= 1'b0;

			case (phase)
				pianoTilesPkg::sweepBackground:
					if (sweepDone)
						phase <= pianoTilesPkg::playing;
				pianoTilesPkg::playing:
				begin
					markScored <= markNext;
					score <= score + pianoTilesPkg::score_t'(hitCount);
					if (missNext)
					begin
						phase <= pianoTilesPkg::sweepGameOver;
						clearTiles <= 1'b1;
					end
					else if (spawnTick)
					begin
						spawn <= spawnNext;
						slotColumn <= spawnColumn;
					end
				end
				pianoTilesPkg::sweepGameOver:
					if (sweepDone)
						phase <= pianoTilesPkg::waiting;
				default:
					if (|keyFall)
					begin
						phase <= pianoTilesPkg::sweepBackground;
						score <= '0;
					end
			endcase
		end
	end

endmodule

`default_nettype wire

/* pianoTiles.sv */
`timescale 1ns/100ps
`default_nettype none

module pianoTiles #(
	parameter int STEP_CYCLES = 416666,
	parameter int SPAWN_CYCLES = 50000000
) (
	input wire logic CLOCK_50,
	input wire logic rstN,
	input wire logic [3:0] KEY,
	output pianoTilesPkg::pixelWrite_t pixel,
	output logic [6:0] hexOnes,
	output logic [6:0] hexTens
);

	logic stepTick;
	logic spawnTick;
	pianoTilesPkg::column_t spawnColumn;
	pianoTilesPkg::column_t slotColumn;
	logic [3:0] spawn;
	logic [3:0] markScored;
	logic clearTiles;
	pianoTilesPkg::phase_t phase;
	pianoTilesPkg::score_t score;
	logic sweepDone;

	// Per-slot state and row requests
	pianoTilesPkg::tileState_t tiles [4];
	logic [3:0] leave;
	logic [3:0] rowReq;
	pianoTilesPkg::yCoord_t rowY [4];
	logic [3:0] rowErase;
	logic [3:0] rowDone;

	tileTimer #(
		.STEP_CYCLES(STEP_CYCLES),
		.SPAWN_CYCLES(SPAWN_CYCLES)
	) timer (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN),
		.playing(phase == pianoTilesPkg::playing),
		.stepTick(stepTick),
		.spawnTick(spawnTick),
		.spawnColumn(spawnColumn)
	);

	for (genvar i = 0; i < 4; i++)
	begin : slotGen
		tileSlot slot (
			.CLOCK_50(CLOCK_50), .rstN(rstN),
			.spawn(spawn[i]), .spawnColumn(slotColumn), .stepTick(stepTick),
			.markScored(markScored[i]), .clear(clearTiles),
			.state(tiles[i]), .leave(leave[i]),
			.rowReq(rowReq[i]), .rowY(rowY[i]), .rowErase(rowErase[i]), .rowDone(rowDone[i])
		);
	end

	gameControl control (
		.CLOCK_50(CLOCK_50), .rstN(rstN), .KEY(KEY),
		.tiles(tiles), .leave(leave), .sweepDone(sweepDone),
		.spawnTick(spawnTick), .spawnColumn(spawnColumn),
		.spawn(spawn), .slotColumn(slotColumn), .markScored(markScored),
		.clearTiles(clearTiles), .phase(phase), .score(score)
	);

	pixelPlotter plotter (
		.CLOCK_50(CLOCK_50), .rstN(rstN), .phase(phase), .tiles(tiles),
		.rowReq(rowReq), .rowY(rowY), .rowErase(rowErase), .rowDone(rowDone),
		.sweepDone(sweepDone), .pixel(pixel)
	);

	scoreDisplay display (
		.score(score),
		.hexOnes(hexOnes),
		.hexTens(hexTens)
	);

endmodule

`default_nettype wire

/* pianoTilesPkg.sv */
`default_nettype none

package pianoTilesPkg;

	// Screen geometry in pixels
	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;
	localparam int COLUMN_W = 35;
	localparam int BORDER_W = 4;
	localparam int TILE_H = 30;

	// Lowest top row that still counts as a hit
	localparam int HIT_TOP = 90;
	// Red bottom row, tiles stop short of it
	localparam int LAST_ROW = 119;

	typedef logic [7:0] xCoord_t;
	typedef logic [6:0] yCoord_t;
	typedef logic [2:0] color_t;
	typedef logic [1:0] column_t;
	typedef logic [7:0] score_t;

	localparam color_t colorTiles = 3'b000;
	localparam color_t colorBackground = 3'b111;
	localparam color_t colorBoundary = 3'b100;
	localparam color_t colorBorder = 3'b010;
	localparam color_t colorGameOver = 3'b001;

	typedef enum logic [1:0] {
		sweepBackground = 2'd0,
		playing = 2'd1,
		sweepGameOver = 2'd2,
		waiting = 2'd3
	} phase_t;

	// One write into the frame buffer
	typedef struct packed {
		logic plot;
		xCoord_t x;
		yCoord_t y;
		color_t color;
	} pixelWrite_t;

	typedef struct packed {
		logic onScreen;
		column_t column;
		yCoord_t yTop;
		logic scored;
	} tileState_t;

	// Left edge of a lane: 4, 43, 82, 121
	function automatic xCoord_t columnX(input column_t column);
		return xCoord_t'(BORDER_W * (int'(column) + 1) + COLUMN_W * int'(column));
	endfunction

endpackage

`default_nettype wire

/* pianoTilesTb.sv */
`timescale 1ns/100ps
`default_nettype none

module pianoTilesTb;

	localparam int STEP_CYCLES = 400;
	localparam int SPAWN_CYCLES = 16000;
	localparam int SWEEP_PIXELS = pianoTilesPkg::SCREEN_W * pianoTilesPkg::SCREEN_H;
	// A tile lives 150 steps from spawn to leaving
	localparam int LIFETIME_CYCLES = 150 * STEP_CYCLES;
	localparam int TIMEOUT_CYCLES = 5 * SWEEP_PIXELS + 4 * LIFETIME_CYCLES + 2 * SPAWN_CYCLES;

	logic CLOCK_50 = 1'b0;
	logic rstN;
	logic [3:0] KEY;
	pianoTilesPkg::pixelWrite_t pixel;
	logic [6:0] hexOnes;
	logic [6:0] hexTens;

	int errorCount = 0;
	int testsFailed = 0;
	int testNumber = 0;
	int testStartErrors = 0;
	int cycleCount = 0;
	logic [7:0] lfsrState = 8'd86;

	// Stream monitor state
	logic checkTiles = 1'b0;
	int rowPos = 0;
	int rowX = 0;
	int rowLine = 0;
	pianoTilesPkg::color_t rowColor;
	int rowsSeen = 0;
	int erasesSeen = 0;
	int trackedTop [4] = '{0, 0, 0, 0};

	pianoTiles #(
		.STEP_CYCLES(STEP_CYCLES),
		.SPAWN_CYCLES(SPAWN_CYCLES)
	) dut (
		.CLOCK_50(CLOCK_50),
		.rstN(rstN),
		.KEY(KEY),
		.pixel(pixel),
		.hexOnes(hexOnes),
		.hexTens(hexTens)
	);

	always #50 CLOCK_50 = ~CLOCK_50;

	function automatic int laneLeft(input int column);
		return pianoTilesPkg::BORDER_W + column * (pianoTilesPkg::BORDER_W + pianoTilesPkg::COLUMN_W);
	endfunction

	// Lane holding x, or -1 on a border
	function automatic int laneOf(input int x);
		for (int c = 0; c < 4; c++)
		begin
			if (x >= laneLeft(c) && x < laneLeft(c) + pianoTilesPkg::COLUMN_W)
				return c;
		end
		return -1;
	endfunction

	function automatic pianoTilesPkg::color_t backgroundColor(input int x, input int y);
		if (y == pianoTilesPkg::LAST_ROW)
			return pianoTilesPkg::colorBoundary;
		if (laneOf(x) < 0)
			return pianoTilesPkg::colorBorder;
		return pianoTilesPkg::colorBackground;
	endfunction

	// Segments gfedcba, lit when low
	function automatic logic [6:0] hexDigit(input int d);
		case (d)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	function automatic logic [7:0] lfsrNext(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic takeBits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			value = (value << 1) | int'(lfsrState[0]);
		end
	endtask

	task automatic comparePixel(input pianoTilesPkg::pixelWrite_t got,
		input pianoTilesPkg::pixelWrite_t expected, output logic match);
		match = (got === expected);
		if (!match)
		begin
			$display("error: pixel got %h expected %h", got, expected);
			errorCount++;
		end
	endtask

	task automatic compareDigits(input pianoTilesPkg::score_t expectedScore);
		logic [6:0] onesExpected;
		logic [6:0] tensExpected;
		onesExpected = hexDigit(int'(expectedScore) % 10);
		tensExpected = hexDigit(int'(expectedScore) / 10);
		if (hexOnes !== onesExpected)
		begin
			$display("error: hexOnes got %h expected %h", hexOnes, onesExpected);
			errorCount++;
		end
		if (hexTens !== tensExpected)
		begin
			$display("error: hexTens got %h expected %h", hexTens, tensExpected);
			errorCount++;
		end
	endtask

	// Waits for (0,0) of a sweep, then checks every pixel in raster order
	task automatic checkSweep(input logic gameOver);
		pianoTilesPkg::pixelWrite_t expected;
		pianoTilesPkg::color_t firstColor;
		logic match;
		logic clean;
		firstColor = gameOver ? pianoTilesPkg::colorGameOver : backgroundColor(0, 0);
		clean = 1'b1;
		do
			@(negedge CLOCK_50);
		while (!(pixel.plot && pixel.x == '0 && pixel.y == '0 && pixel.color == firstColor));
		for (int n = 0; n < SWEEP_PIXELS; n++)
		begin
			if (n != 0)
				@(negedge CLOCK_50);
			expected.plot = 1'b1;
			expected.x = pianoTilesPkg::xCoord_t'(n % pianoTilesPkg::SCREEN_W);
			expected.y = pianoTilesPkg::yCoord_t'(n / pianoTilesPkg::SCREEN_W);
			expected.color = gameOver ? pianoTilesPkg::colorGameOver
				: backgroundColor(n % pianoTilesPkg::SCREEN_W, n / pianoTilesPkg::SCREEN_W);
			if (clean)
			begin
				comparePixel(pixel, expected, match);
				clean = match;
			end
			if (n == 0)
			begin
				@(posedge CLOCK_50);
				checkTiles = 1'b0;
			end
		end
	endtask

	task automatic pressKey(input int column, output int hold);
		int bits;
		takeBits(3, bits);
		hold = bits + 1;
		@(negedge CLOCK_50);
		KEY[3 - column] = 1'b0;
		repeat (hold) @(negedge CLOCK_50);
		KEY = 4'hF;
	endtask

	task automatic waitDigits(input pianoTilesPkg::score_t expectedScore, input int cycles);
		int n;
		n = 0;
		while (n < cycles && !(hexOnes == hexDigit(int'(expectedScore) % 10)
			&& hexTens == hexDigit(int'(expectedScore) / 10)))
		begin
			@(negedge CLOCK_50);
			n++;
		end
		compareDigits(expectedScore);
	endtask

	task automatic endTest(input string name);
		@(posedge CLOCK_50);
		testNumber++;
		if (errorCount == testStartErrors)
			$display("test %0d %s: ok", testNumber, name);
		else
		begin
			testsFailed++;
			$display("test %0d %s: %0d errors", testNumber, name, errorCount - testStartErrors);
		end
		testStartErrors = errorCount;
	endtask

	// Tile rows must start at a lane edge and run 35 pixels without a gap
	always @(negedge CLOCK_50)
	begin : streamMonitor
		int lane;
		if (!checkTiles)
		begin
			rowPos = 0;
			for (int c = 0; c < 4; c++)
				trackedTop[c] = 0;
		end
		else if (rowPos != 0)
		begin
			if (!pixel.plot || int'(pixel.x) != rowX + rowPos || int'(pixel.y) != rowLine
				|| pixel.color != rowColor)
			begin
				$display("tile row at y %0d broke off after %0d of 35 pixels", rowLine, rowPos);
				errorCount++;
				rowPos = 0;
			end
			else if (rowPos == pianoTilesPkg::COLUMN_W - 1)
			begin
				rowPos = 0;
				rowsSeen++;
			end
			else
				rowPos++;
		end
		else if (pixel.plot && (pixel.color == pianoTilesPkg::colorTiles
			|| pixel.color == pianoTilesPkg::colorBackground))
		begin
			lane = laneOf(int'(pixel.x));
			if (lane < 0 || int'(pixel.x) != laneLeft(lane))
			begin
				$display("tile row starts at x %0d, not at the left edge of a lane", pixel.x);
				errorCount++;
			end
			else if (int'(pixel.y) == pianoTilesPkg::LAST_ROW)
			begin
				$display("tile write lands on the bottom row at x %0d", pixel.x);
				errorCount++;
			end
			else
			begin
				rowPos = 1;
				rowX = int'(pixel.x);
				rowLine = int'(pixel.y);
				rowColor = pixel.color;
				// An erase moves the lowest tile of this lane down
				if (pixel.color == pianoTilesPkg::colorBackground)
				begin
					erasesSeen++;
					if (rowLine + 1 > trackedTop[lane] || trackedTop[lane] >= pianoTilesPkg::LAST_ROW)
						trackedTop[lane] = rowLine + 1;
				end
			end
		end
	end

	always @(posedge CLOCK_50)
	begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial
	begin : testSequence
		int column;
		int hold;
		int totalErrors;
		KEY = 4'hF;
		rstN = 1'b0;
		repeat (8) @(negedge CLOCK_50);
		rstN = 1'b1;

		checkSweep(1'b0);
		compareDigits(8'd0);
		endTest("background sweep");
		checkTiles = 1'b1;

		do
			@(posedge CLOCK_50);
		while (rowsSeen < 40 || erasesSeen == 0);
		endTest("tile geometry");

		for (int h = 1; h <= 3; h++)
		begin
			column = -1;
			while (column < 0)
			begin
				@(posedge CLOCK_50);
				for (int c = 0; c < 4; c++)
				begin
					if (trackedTop[c] >= 95 && trackedTop[c] <= 110)
						column = c;
				end
			end
			pressKey(column, hold);
			waitDigits(pianoTilesPkg::score_t'(h), 10 - hold);
			do
				@(posedge CLOCK_50);
			while (trackedTop[column] >= 95 && trackedTop[column] <= 110);
		end
		endTest("hits");

		column = -1;
		@(posedge CLOCK_50);
		for (int c = 0; c < 4; c++)
		begin
			if (column < 0 && (trackedTop[c] < 85 || trackedTop[c] >= pianoTilesPkg::LAST_ROW))
				column = c;
		end
		if (column < 0)
		begin
			$display("no column was free of tiles in the hit zone");
			errorCount++;
			column = 0;
		end
		pressKey(column, hold);
		checkSweep(1'b1);
		compareDigits(8'd3);
		endTest("miss");

		takeBits(2, column);
		pressKey(column, hold);
		checkSweep(1'b0);
		compareDigits(8'd0);
		endTest("restart");
		checkTiles = 1'b1;

		do
			@(posedge CLOCK_50);
		while (!(trackedTop[0] >= pianoTilesPkg::LAST_ROW || trackedTop[1] >= pianoTilesPkg::LAST_ROW
			|| trackedTop[2] >= pianoTilesPkg::LAST_ROW || trackedTop[3] >= pianoTilesPkg::LAST_ROW));
		checkSweep(1'b1);
		endTest("timeout loss");

		totalErrors = errorCount + dut.assertions.failCount;
		$display("summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
			testNumber, testsFailed, errorCount, dut.assertions.failCount);
		if (totalErrors == 0 && testsFailed == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* pianoTiles_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module pianoTilesAsserts (
	input wire logic CLOCK_50,
	input wire logic rstN,
	input wire pianoTilesPkg::pixelWrite_t pixel
);

	int failCount = 0;

	xOnScreen: assert property (@(posedge CLOCK_50) disable iff (!rstN)
		pixel.plot |-> int'(pixel.x) < pianoTilesPkg::SCREEN_W)
	else
	begin
		$error("pixel x %0d is beyond the screen width", pixel.x);
		failCount++;
	end

	yOnScreen: assert property (@(posedge CLOCK_50) disable iff (!rstN)
		pixel.plot |-> int'(pixel.y) < pianoTilesPkg::SCREEN_H)
	else
	begin
		$error("pixel y %0d is beyond the screen height", pixel.y);
		failCount++;
	end

	// Red boundary row is never covered by a tile
	boundaryKept: assert property (@(posedge CLOCK_50) disable iff (!rstN)
		(pixel.plot && pixel.color == pianoTilesPkg::colorTiles)
		|-> int'(pixel.y) != pianoTilesPkg::LAST_ROW)
	else
	begin
		$error("black tile pixel written on the boundary row at x %0d", pixel.x);
		failCount++;
	end

endmodule

bind pianoTiles pianoTilesAsserts assertions (
	.CLOCK_50(CLOCK_50),
	.rstN(rstN),
	.pixel(pixel)
);

`default_nettype wire

/* pixelPlotter.sv */
`timescale 1ns/100ps
`default_nettype none

module pixelPlotter (
	input wire logic CLOCK_50,
	input wire logic rstN,
	input wire pianoTilesPkg::phase_t phase,
	input wire pianoTilesPkg::tileState_t tiles [4],
	input wire logic [3:0] rowReq,
	input wire pianoTilesPkg::yCoord_t rowY [4],
	input wire logic [3:0] rowErase,
	output logic [3:0] rowDone,
	output logic sweepDone,
	output pianoTilesPkg::pixelWrite_t pixel
);

	pianoTilesPkg::xCoord_t sweepX;
	pianoTilesPkg::yCoord_t sweepY;
	// Set once the current phase's sweep has been written
	logic sweepLatch;
	logic sweepActive;

	logic rowBusy;
	logic [1:0] rowIdx;
	logic [5:0] rowCount;
	pianoTilesPkg::xCoord_t rowBase;
	pianoTilesPkg::yCoord_t rowLine;
	pianoTilesPkg::color_t rowColor;

	logic [3:0] pending;
	logic [1:0] grantIdx;
	pianoTilesPkg::xCoord_t grantBase;

	function automatic pianoTilesPkg::color_t backgroundColor(
		input pianoTilesPkg::xCoord_t x, input pianoTilesPkg::yCoord_t y);
		logic border;
		border = 1'b0;
		for (int k = 0; k < 5; k++)
		begin
			if (int'(x) >= k * (pianoTilesPkg::COLUMN_W + pianoTilesPkg::BORDER_W)
				&& int'(x) < k * (pianoTilesPkg::COLUMN_W + pianoTilesPkg::BORDER_W)
				+ pianoTilesPkg::BORDER_W)
				border = 1'b1;
		end
		if (y == pianoTilesPkg::LAST_ROW)
			return pianoTilesPkg::colorBoundary;
		else if (border)
			return pianoTilesPkg::colorBorder;
		return pianoTilesPkg::colorBackground;
	endfunction

	assign sweepActive = !sweepLatch && (phase == pianoTilesPkg::sweepBackground
		|| phase == pianoTilesPkg::sweepGameOver);

	// A slot being answered this cycle still shows its old request
	assign pending = rowReq & ~rowDone;

	always_comb
	begin
		grantIdx = '0;
		for (int i = 3; i >= 0; i--)
		begin
			if (pending[i])
				grantIdx = 2'(i);
		end
	end

	assign grantBase = pianoTilesPkg::columnX(tiles[grantIdx].column);

	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			pixel <= '0;
			sweepX <= '0;
			sweepY <= '0;
			sweepLatch <= 1'b0;
			sweepDone <= 1'b0;
			rowBusy <= 1'b0;
			rowIdx <= '0;
			rowCount <= '0;
			rowBase <= '0;
			rowLine <= '0;
			rowColor <= '0;
			rowDone <= '0;
		end
		else
		begin
			pixel.plot <= 1'b0;
			rowDone <= '0;
			sweepDone <= 1'b0;
			if (phase == pianoTilesPkg::playing || phase == pianoTilesPkg::waiting)
				sweepLatch <= 1'b0;

			if (rowBusy)
			begin
				// Row in progress always finishes, even across game over
				pixel <= '{plot: 1'b1, x: rowBase + pianoTilesPkg::xCoord_t'(rowCount),
					y: rowLine, color: rowColor};
				rowCount <= rowCount + 1'b1;
				if (rowCount == 6'(pianoTilesPkg::COLUMN_W - 1))
				begin
					rowBusy <= 1'b0;
					rowDone[rowIdx] <= 1'b1;
				end
			end
			else if (sweepActive)
			begin
				pixel <= '{plot: 1'b1, x: sweepX, y: sweepY,
					color: (phase == pianoTilesPkg::sweepGameOver)
					? pianoTilesPkg::colorGameOver : backgroundColor(sweepX, sweepY)};
				if (sweepX == pianoTilesPkg::SCREEN_W - 1)
				begin
					sweepX <= '0;
					if (sweepY == pianoTilesPkg::SCREEN_H - 1)
					begin
						sweepY <= '0;
						sweepDone <= 1'b1;
						sweepLatch <= 1'b1;
					end
					else
						sweepY <= sweepY + 1'b1;
				end
				else
					sweepX <= sweepX + 1'b1;
			end
			else if (phase == pianoTilesPkg::playing && |pending)
			begin
				// First pixel goes out in the grant cycle
				rowBusy <= 1'b1;
				rowIdx <= grantIdx;
				rowCount <= 6'd1;
				rowBase <= grantBase;
				rowLine <= rowY[grantIdx];
				rowColor <= rowErase[grantIdx] ? pianoTilesPkg::colorBackground
					: pianoTilesPkg::colorTiles;
				pixel <= '{plot: 1'b1, x: grantBase, y: rowY[grantIdx],
					color: rowErase[grantIdx] ? pianoTilesPkg::colorBackground
					: pianoTilesPkg::colorTiles};
			end
		end
	end

endmodule

`default_nettype wire

/* scoreDisplay.sv */
`timescale 1ns/100ps
`default_nettype none

module scoreDisplay (
	input wire pianoTilesPkg::score_t score,
	output logic [6:0] hexOnes,
	output logic [6:0] hexTens
);

	pianoTilesPkg::score_t tens;
	pianoTilesPkg::score_t ones;

	// Active-low segments, anything above 9 stays dark
	function automatic logic [6:0] sevenSeg(input pianoTilesPkg::score_t digit);
		case (digit)
			8'd0: return 7'b1000000;
			8'd1: return 7'b1111001;
			8'd2: return 7'b0100100;
			8'd3: return 7'b0110000;
			8'd4: return 7'b0011001;
			8'd5: return 7'b0010010;
			8'd6: return 7'b0000010;
			8'd7: return 7'b1111000;
			8'd8: return 7'b0000000;
			8'd9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	assign tens = score / 8'd10;
	assign ones = score % 8'd10;

	assign hexTens = sevenSeg(tens);
	assign hexOnes = sevenSeg(ones);

endmodule

`default_nettype wire

/* tileSlot.sv */
`timescale 1ns/100ps
`default_nettype none

module tileSlot (
	input wire logic CLOCK_50,
	input wire logic rstN,
	input wire logic spawn,
	input wire pianoTilesPkg::column_t spawnColumn,
	input wire logic stepTick,
	input wire logic markScored,
	input wire logic clear,
	output pianoTilesPkg::tileState_t state,
	output logic leave,
	output logic rowReq,
	output pianoTilesPkg::yCoord_t rowY,
	output logic rowErase,
	input wire logic rowDone
);

	localparam int HEIGHT_W = $clog2(pianoTilesPkg::TILE_H + 1);

	pianoTilesPkg::tileState_t tile;
	logic [HEIGHT_W-1:0] height;
	// Bottom row still owed after the current erase
	logic drawPending;

	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			tile <= '0;
			height <= '0;
			drawPending <= 1'b0;
			leave <= 1'b0;
			rowReq <= 1'b0;
			rowY <= '0;
			rowErase <= 1'b0;
		end
		else
		begin
			leave <= 1'b0;
			if (clear)
			begin
				tile.onScreen <= 1'b0;
				tile.scored <= 1'b0;
				rowReq <= 1'b0;
				drawPending <= 1'b0;
			end
			else if (spawn)
			begin
				tile <= '{onScreen: 1'b1, column: spawnColumn, yTop: '0, scored: 1'b0};
				height <= '0;
				rowReq <= 1'b0;
				drawPending <= 1'b0;
			end
			else
			begin
				if (markScored)
					tile.scored <= 1'b1;

				if (rowReq)
				begin
					// Request held until the plotter is done, steps are dropped meanwhile
					if (rowDone && drawPending)
					begin
						rowY <= pianoTilesPkg::yCoord_t'(int'(tile.yTop) + pianoTilesPkg::TILE_H - 1);
						rowErase <= 1'b0;
						drawPending <= 1'b0;
					end
					else if (rowDone)
						rowReq <= 1'b0;
				end
				else if (tile.onScreen && tile.yTop == pianoTilesPkg::LAST_ROW)
				begin
					tile.onScreen <= 1'b0;
					leave <= 1'b1;
				end
				else if (tile.onScreen && stepTick)
				begin
					rowReq <= 1'b1;
					if (height < pianoTilesPkg::TILE_H)
					begin
						// Still growing in from the top edge
						rowY <= pianoTilesPkg::yCoord_t'(height);
						rowErase <= 1'b0;
						height <= height + 1'b1;
					end
					else
					begin
						rowY <= tile.yTop;
						rowErase <= 1'b1;
						tile.yTop <= tile.yTop + 1'b1;
						drawPending <= (int'(tile.yTop) + pianoTilesPkg::TILE_H
							< pianoTilesPkg::LAST_ROW);
					end
				end
			end
		end
	end

	assign state = tile;

endmodule

`default_nettype wire

/* tileTimer.sv */
`timescale 1ns/100ps
`default_nettype none

module tileTimer #(
	parameter int STEP_CYCLES = 416666,
	parameter int SPAWN_CYCLES = 50000000
) (
	input wire logic CLOCK_50,
	input wire logic rstN,
	input wire logic playing,
	output logic stepTick,
	output logic spawnTick,
	output pianoTilesPkg::column_t spawnColumn
);

	localparam int STEP_W = $clog2(STEP_CYCLES);
	localparam int SPAWN_W = $clog2(SPAWN_CYCLES);

	logic [STEP_W-1:0] stepCount;
	logic [SPAWN_W-1:0] spawnCount;
	logic [23:0] lfsr;

	// Both periods restart whenever the game is not running
	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
		begin
			stepCount <= '0;
			spawnCount <= '0;
			stepTick <= 1'b0;
			spawnTick <= 1'b0;
		end
		else if (!playing)
		begin
			stepCount <= '0;
			spawnCount <= '0;
			stepTick <= 1'b0;
			spawnTick <= 1'b0;
		end
		else
		begin
			stepTick <= (stepCount == STEP_W'(STEP_CYCLES - 1));
			spawnTick <= (spawnCount == SPAWN_W'(SPAWN_CYCLES - 1));
			if (stepCount == STEP_W'(STEP_CYCLES - 1))
				stepCount <= '0;
			else
				stepCount <= stepCount + 1'b1;
			if (spawnCount == SPAWN_W'(SPAWN_CYCLES - 1))
				spawnCount <= '0;
			else
				spawnCount <= spawnCount + 1'b1;
		end
	end

	// Free-running column picker, taps 24 23 18 17
	always_ff @(posedge CLOCK_50 or negedge rstN)
	begin
		if (!rstN)
			lfsr <= 24'h800001;
		else
			lfsr <= {lfsr[22:0], lfsr[23] ^ lfsr[22] ^ lfsr[17] ^ lfsr[16]};
	end

	assign spawnColumn = lfsr[1:0];

endmodule

`default_nettype wire
